/* verilog/trace_pkg.sv */
/*
  Shared widths, types and register map of the pipeline trace unit.
  The record store assumes that fewer than RECORD_DEPTH instructions are in flight.
  Wishbone addresses are word addresses on a 32-bit read data bus.
*/
package trace_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sizes.
    ////////////////////////////////////////////////////////////////////////////
    localparam int RECORD_DEPTH = 16;                // Records held by ID.
    localparam int FIFO_DEPTH   = 8;                 // Entries waiting for software.
    localparam int REC_AW       = $clog2(RECORD_DEPTH);
    localparam int FIFO_AW      = $clog2(FIFO_DEPTH);

    typedef logic [15:0] instr_id_t;                 // Wrapping instruction ID.
    typedef logic [7:0]  evt_t;                      // Stage event code.
    typedef logic [7:0]  opcode_t;                   // Opcode class from decode.
    typedef logic [3:0]  stall_cnt_t;                // Saturating stall cycles.
    typedef logic [31:0] wb_data_t;
    typedef logic [1:0]  wb_addr_t;

    localparam stall_cnt_t STALL_MAX = '1;           // Saturation value.
    localparam int LOST_BIT          = $bits(evt_t) - 1;  // Lost-record marker in wb_evt.
    localparam int STAT_EMPTY_BIT    = 8;
    localparam int STAT_OVF_BIT      = 9;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline and record structures.
    ////////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic      valid;
        instr_id_t id;
    } stage_tag_t;

    typedef struct packed {
        stage_tag_t fetch;
        stage_tag_t decode;
        stage_tag_t execute;
        stage_tag_t memory;
        stage_tag_t wb;
    } pipe_tags_t;

    typedef struct packed {
        opcode_t opcode;                             // Valid with decode_evt.
        evt_t    fetch_evt;
        evt_t    decode_evt;
        evt_t    exec_evt;
        evt_t    mem_evt;
        evt_t    wb_evt;
    } stage_evt_t;

    typedef struct packed {
        instr_id_t  id;
        opcode_t    opcode;
        evt_t       fetch_evt;
        evt_t       decode_evt;
        evt_t       exec_evt;
        evt_t       mem_evt;
        evt_t       wb_evt;
        stall_cnt_t stall_cnt;
        logic       halt;
    } trace_rec_t;

    // Wishbone register map.
    localparam wb_addr_t ADDR_INFO = 2'd0;           // ID, opcode, stall count, halt.
    localparam wb_addr_t ADDR_EVTS = 2'd1;           // Fetch to memory events.
    localparam wb_addr_t ADDR_WB   = 2'd2;           // Write-back event. Pops.
    localparam wb_addr_t ADDR_STAT = 2'd3;           // Count, empty, overflow. Clears overflow.

endpackage

/* verilog/trace_id_tracker.sv */
/*
  Instruction ID and valid tracking through the five pipeline stages.
  stall holds fetch and decode and sends a bubble into execute.
  After hlt the tracker accepts no fetch until reset.
  The fetch tag is combinational from the inputs of the same cycle.
*/
`timescale 1ns/10ps

module trace_id_tracker (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  fetch_valid,  // Instruction presented in fetch.
    input  logic                  stall,        // Hold fetch and decode.
    input  logic                  hlt,          // Decode instruction is a halt.
    output trace_pkg::pipe_tags_t tags,         // ID and valid of every stage.
    output logic                  halt_mark,    // Mark decode ID as halt.
    output logic                  stall_inc     // Count a stall on decode ID.
);
    import trace_pkg::*;

    instr_id_t  next_id;    // ID for the next accepted instruction.
    logic       halted;     // Fetch frozen until reset.
    logic       accept;     // Instruction enters the pipe this cycle.
    stage_tag_t fetch_tag;
    stage_tag_t dec_q;
    stage_tag_t exe_q;
    stage_tag_t mem_q;
    stage_tag_t wb_q;

    ////////////////////////////////////////////////////////////////////////////
    // Fetch acceptance.
    ////////////////////////////////////////////////////////////////////////////

    // The fetch after a halt is ignored, also in the cycle that hlt is seen.
    assign accept = fetch_valid && !stall && !halted && !hlt;

    assign fetch_tag.valid = accept;
    assign fetch_tag.id    = next_id;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            next_id <= '0;                           // IDs start at zero.
            halted  <= 1'b0;
        end else begin
            if (accept) begin
                next_id <= next_id + 1'b1;           // Wraps at 16 bits.
            end
            if (hlt) begin
                halted <= 1'b1;                      // Sticky until reset.
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage propagation.
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_q <= '0;
            exe_q <= '0;
            mem_q <= '0;
            wb_q  <= '0;
        end else begin
            if (!stall) begin
                dec_q <= fetch_tag;                  // Decode holds while stalled.
            end
            exe_q.valid <= dec_q.valid && !stall;    // Bubble during a stall.
            exe_q.id    <= dec_q.id;
            mem_q       <= exe_q;                    // Memory and wb keep moving.
            wb_q        <= mem_q;
        end
    end

    // Decode side requests to the record store.
    assign halt_mark = hlt && dec_q.valid;
    assign stall_inc = stall && dec_q.valid;         // One per stalled decode cycle.

    assign tags.fetch   = fetch_tag;
    assign tags.decode  = dec_q;
    assign tags.execute = exe_q;
    assign tags.memory  = mem_q;
    assign tags.wb      = wb_q;

endmodule

/* verilog/trace_record_store.sv */
/*
  Per-instruction record memory indexed by the low ID bits.
  Each stage writes its own fields in the cycle its tag is valid.
  The record leaves one cycle after its wb cycle, merged with the wb event.
*/
`timescale 1ns/10ps

module trace_record_store (
    input  logic                  clk,
    input  logic                  rst_n,
    input  trace_pkg::pipe_tags_t tags,
    input  trace_pkg::stage_evt_t evt,
    input  logic                  halt_mark,
    input  logic                  stall_inc,
    output trace_pkg::trace_rec_t rec,
    output logic                  rec_valid
);
    import trace_pkg::*;

    trace_rec_t        mem [RECORD_DEPTH];   // Record per in-flight ID.
    logic [REC_AW-1:0] f_idx;
    logic [REC_AW-1:0] d_idx;
    logic [REC_AW-1:0] e_idx;
    logic [REC_AW-1:0] m_idx;
    logic [REC_AW-1:0] w_idx;

    assign f_idx = tags.fetch.id[REC_AW-1:0];
    assign d_idx = tags.decode.id[REC_AW-1:0];
    assign e_idx = tags.execute.id[REC_AW-1:0];
    assign m_idx = tags.memory.id[REC_AW-1:0];
    assign w_idx = tags.wb.id[REC_AW-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // Event capture.
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (tags.fetch.valid) begin
            // New ID. Start a clean record.
            mem[f_idx] <= '{id: tags.fetch.id, fetch_evt: evt.fetch_evt, default: '0};
        end
        if (tags.decode.valid) begin
            mem[d_idx].opcode     <= evt.opcode;     // Last decode cycle wins.
            mem[d_idx].decode_evt <= evt.decode_evt;
            if (stall_inc && mem[d_idx].stall_cnt != STALL_MAX) begin
                mem[d_idx].stall_cnt <= mem[d_idx].stall_cnt + 1'b1;
            end
            if (halt_mark) begin
                mem[d_idx].halt <= 1'b1;
            end
        end
        if (tags.execute.valid) begin
            mem[e_idx].exec_evt <= evt.exec_evt;
        end
        if (tags.memory.valid) begin
            mem[m_idx].mem_evt <= evt.mem_evt;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Retirement read.
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (tags.wb.valid) begin
            rec        <= mem[w_idx];
            rec.wb_evt <= evt.wb_evt;                // Taken live from the wb stage.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rec_valid <= 1'b0;
        end else begin
            rec_valid <= tags.wb.valid;              // One pulse per retired ID.
        end
    end

endmodule

/* verilog/trace_retire_packer.sv */
/*
  Final stage before the trace queue.
  Checks retirement order against the last retired ID plus one.
  A gap in the IDs sets the top bit of wb_evt as a lost-record marker.
  The expected ID starts at zero after reset.
*/
`timescale 1ns/10ps

module trace_retire_packer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  trace_pkg::trace_rec_t rec,
    input  logic                  rec_valid,
    output trace_pkg::trace_rec_t entry,
    output logic                  push
);
    import trace_pkg::*;

    instr_id_t exp_id;     // Next ID expected to retire.
    logic      id_gap;     // Record does not follow the last one.

    assign id_gap = rec.id != exp_id;

    ////////////////////////////////////////////////////////////////////////////
    // Order tracking.
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exp_id <= '0;
            push   <= 1'b0;
        end else begin
            push <= rec_valid;                       // One cycle behind the record.
            if (rec_valid) begin
                exp_id <= rec.id + 1'b1;             // Resync on every record.
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Entry register.
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rec_valid) begin
            entry <= rec;
            if (id_gap) begin
                // A record was lost or replaced in the store.
                entry.wb_evt[LOST_BIT] <= 1'b1;
            end
        end
    end

endmodule

/* verilog/trace_fifo_wb.sv */
/*
  Trace queue with a Wishbone classic read port.
  A push into a full queue is dropped and sets the sticky overflow flag.
  The next stored entry then carries the lost-record marker in wb_evt.
  Reads of ADDR_WB pop. Reads of ADDR_STAT clear overflow. Writes are ignored.
*/
`timescale 1ns/10ps

module trace_fifo_wb (
    input  logic                  clk,
    input  logic                  rst_n,
    input  trace_pkg::trace_rec_t entry,
    input  logic                  push,
    input  logic                  cyc,
    input  logic                  stb,
    input  logic                  we,
    input  trace_pkg::wb_addr_t   adr,
    output trace_pkg::wb_data_t   dat_r,
    output logic                  ack
);
    import trace_pkg::*;

    trace_rec_t         q [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;         // 0 to FIFO_DEPTH.
    logic               overflow;      // Sticky until status read.
    logic               lost_pend;     // Mark the next stored entry.
    logic               full;
    logic               empty;
    logic               push_ok;
    logic               drop;
    logic               wb_req;        // New bus cycle this clock.
    logic               rd_req;
    logic               pop;
    trace_rec_t         head;
    trace_rec_t         in_ent;
    wb_data_t           rd_data;

    assign full    = count == (FIFO_AW + 1)'(FIFO_DEPTH);
    assign empty   = count == '0;
    assign push_ok = push && !full;
    assign drop    = push && full;
    assign wb_req  = cyc && stb && !ack;             // Ack once per strobe.
    assign rd_req  = wb_req && !we;
    assign pop     = rd_req && adr == ADDR_WB && !empty;
    assign head    = q[rd_ptr];

    always_comb begin
        in_ent = entry;
        if (lost_pend) begin
            in_ent.wb_evt[LOST_BIT] = 1'b1;          // Entries were dropped before it.
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Queue control.
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            overflow  <= 1'b0;
            lost_pend <= 1'b0;
            ack       <= 1'b0;
        end else begin
            ack <= wb_req;
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_ok, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;             // Both or neither.
            endcase
            if (drop) begin
                overflow <= 1'b1;                    // Set wins over a clear.
            end else if (rd_req && adr == ADDR_STAT) begin
                overflow <= 1'b0;
            end
            if (drop) begin
                lost_pend <= 1'b1;
            end else if (push_ok) begin
                lost_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            q[wr_ptr] <= in_ent;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Register map.
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        rd_data = '0;                                // Empty queue reads zero.
        case (adr)
            ADDR_INFO: if (!empty) begin
                rd_data[15:0]  = head.id;
                rd_data[23:16] = head.opcode;
                rd_data[27:24] = head.stall_cnt;
                rd_data[28]    = head.halt;
            end
            ADDR_EVTS: if (!empty) begin
                rd_data = {head.mem_evt, head.exec_evt, head.decode_evt, head.fetch_evt};
            end
            ADDR_WB: if (!empty) begin
                rd_data[7:0] = head.wb_evt;
            end
            default: begin
                rd_data[FIFO_AW:0]     = count;      // Status word.
                rd_data[STAT_EMPTY_BIT] = empty;
                rd_data[STAT_OVF_BIT]   = overflow;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (wb_req) begin
            dat_r <= we ? '0 : rd_data;              // Sampled with the request.
        end
    end

endmodule

/* verilog/pipeline_trace_top.sv */
/*
  Pipeline trace unit top level.
  The CPU side has no handshake. A full queue loses records.
  Software reads records through the Wishbone classic slave port.
*/
`timescale 1ns/10ps

module pipeline_trace_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  fetch_valid,
    input  logic                  stall,
    input  logic                  hlt,
    input  trace_pkg::stage_evt_t evt,          // Event codes of all stages.
    input  logic                  cyc,
    input  logic                  stb,
    input  logic                  we,
    input  trace_pkg::wb_addr_t   adr,
    output trace_pkg::wb_data_t   dat_r,
    output logic                  ack
);
    import trace_pkg::*;

    pipe_tags_t tags;          // Tracker to store.
    logic       halt_mark;
    logic       stall_inc;
    trace_rec_t rec;           // Store to packer.
    logic       rec_valid;
    trace_rec_t entry;         // Packer to queue.
    logic       push;

    ////////////////////////////////////////////////////////////////////////////
    // Trace chain.
    ////////////////////////////////////////////////////////////////////////////
    trace_id_tracker i_trace_id_tracker (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .stall       (stall),
        .hlt         (hlt),
        .tags        (tags),
        .halt_mark   (halt_mark),
        .stall_inc   (stall_inc)
    );

    trace_record_store i_trace_record_store (
        .clk       (clk),
        .rst_n     (rst_n),
        .tags      (tags),
        .evt       (evt),
        .halt_mark (halt_mark),
        .stall_inc (stall_inc),
        .rec       (rec),
        .rec_valid (rec_valid)
    );

    trace_retire_packer i_trace_retire_packer (
        .clk       (clk),
        .rst_n     (rst_n),
        .rec       (rec),
        .rec_valid (rec_valid),
        .entry     (entry),
        .push      (push)
    );

    trace_fifo_wb i_trace_fifo_wb (
        .clk   (clk),
        .rst_n (rst_n),
        .entry (entry),
        .push  (push),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_r (dat_r),
        .ack   (ack)
    );

endmodule

/* verification/pipeline_trace_checker.sv */
/*
  Assertions on the ID tracker and the Wishbone side of the trace queue.
  Bound twice. Ports that the target module lacks are tied off.
*/
`timescale 1ns/10ps

module trace_checker (
    input  logic                             clk,
    input  logic                             rst_n,
    input  trace_pkg::pipe_tags_t            tags,
    input  trace_pkg::instr_id_t             next_id,
    input  logic                             halted,
    input  logic                             ack,
    input  logic                             push,
    input  logic                             full,
    input  logic                             overflow,
    input  logic [trace_pkg::FIFO_AW-1:0]    wr_ptr
);
    import trace_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Tracker.
    ////////////////////////////////////////////////////////////////////////////
    // One accepted instruction per cycle at most.
    id_step: assert property (@(posedge clk) disable iff (!rst_n)
        tags.fetch.valid |=> next_id == $past(next_id) + 1'b1)
        else $error("ID did not advance by one on an accepted fetch");
    id_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !tags.fetch.valid |=> next_id == $past(next_id))
        else $error("ID moved without an accepted fetch");
    no_fetch_halted: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> !tags.fetch.valid)
        else $error("Fetch tag valid after halt");

    ////////////////////////////////////////////////////////////////////////////
    // Queue and bus.
    ////////////////////////////////////////////////////////////////////////////
    ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        ack |=> !ack)
        else $error("ack high for two cycles");
    full_drop: assert property (@(posedge clk) disable iff (!rst_n)
        push && full |=> overflow && wr_ptr == $past(wr_ptr))   // Dropped, not stored.
        else $error("Push into a full queue was stored");

endmodule

bind trace_id_tracker trace_checker i_tracker_chk (
    .clk      (clk),
    .rst_n    (rst_n),
    .tags     (tags),
    .next_id  (next_id),
    .halted   (halted),
    .ack      (1'b0),
    .push     (1'b0),
    .full     (1'b0),
    .overflow (1'b0),
    .wr_ptr   ('0)
);

bind trace_fifo_wb trace_checker i_fifo_chk (
    .clk      (clk),
    .rst_n    (rst_n),
    .tags     ('0),
    .next_id  ('0),
    .halted   (1'b0),
    .ack      (ack),
    .push     (push),
    .full     (full),
    .overflow (overflow),
    .wr_ptr   (wr_ptr)
);

/* verification/pipeline_trace_tb.sv */
/*
  Testbench for the pipeline trace unit.
  A cycle model of the five stages builds the expected records from the table.
  Each drain starts once the model pipeline is empty, so pushes and pops never meet.
  The halt block comes last, since fetch stays frozen until reset.
*/
`timescale 1ns/10ps

module pipeline_trace_tb;
    import trace_pkg::*;

    typedef struct packed {
        logic    fetch_valid;
        logic    stall;
        logic    hlt;
        logic    drain;          // Empty the pipe and read the FIFO after this row.
        opcode_t opcode;
    } row_t;

    logic       clk;
    logic       rst_n;
    logic       fetch_valid;
    logic       stall;
    logic       hlt;
    stage_evt_t evt;
    logic       cyc;
    logic       stb;
    logic       we;
    wb_addr_t   adr;
    wb_data_t   dat_r;
    logic       ack;

    row_t       rows [$];                  // Stimulus table.
    bit         rows_ready;
    int         err_cnt;
    stage_tag_t m_dec;                     // Model stage contents.
    stage_tag_t m_exe;
    stage_tag_t m_mem;
    stage_tag_t m_wb;
    instr_id_t  m_next_id;
    logic       m_halted;
    logic       m_ovf;                     // Expected overflow flag.
    logic       m_lost;                    // Next stored record carries the marker.
    opcode_t    op_of   [RECORD_DEPTH];
    stall_cnt_t scnt_of [RECORD_DEPTH];
    logic       halt_of [RECORD_DEPTH];
    trace_rec_t exp_q [$];                 // Expected FIFO contents.

    pipeline_trace_top i_pipeline_trace_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .stall       (stall),
        .hlt         (hlt),
        .evt         (evt),
        .cyc         (cyc),
        .stb         (stb),
        .we          (we),
        .adr         (adr),
        .dat_r       (dat_r),
        .ack         (ack)
    );

    always #20 clk = ~clk;                 // 40 ns period.

    // Code of one stage of one instruction. Top bit stays free for the marker.
    function automatic evt_t evt_code(input instr_id_t id, input int stage);
        return {1'b0, id[3:0], 3'(stage)};
    endfunction

    task automatic check_equal(input logic [31:0] got, input logic [31:0] want,
                               input string msg);
        if (got !== want) begin
            err_cnt++;
            $display("Fail at %0t: %s, read %h, expected %h", $time, msg, got, want);
            $display("Regression failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic add_row(input logic fv, input logic st, input logic h, input logic dr);
        row_t row;
        row.fetch_valid = fv;
        row.stall       = st;
        row.hlt         = h;
        row.drain       = dr;
        row.opcode      = 8'($urandom);
        rows.push_back(row);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stage model.
    ////////////////////////////////////////////////////////////////////////////
    task automatic retire_model(input instr_id_t id);
        trace_rec_t        r;
        logic [REC_AW-1:0] k;
        k            = id[REC_AW-1:0];
        r.id         = id;
        r.opcode     = op_of[k];
        r.fetch_evt  = evt_code(id, 0);
        r.decode_evt = evt_code(id, 1);
        r.exec_evt   = evt_code(id, 2);
        r.mem_evt    = evt_code(id, 3);
        r.wb_evt     = evt_code(id, 4);
        r.stall_cnt  = scnt_of[k];
        r.halt       = halt_of[k];
        if (exp_q.size() == FIFO_DEPTH) begin
            m_ovf  = 1'b1;                 // Queue full. Record is dropped.
            m_lost = 1'b1;
        end else begin
            if (m_lost) begin
                r.wb_evt[LOST_BIT] = 1'b1;
            end
            m_lost = 1'b0;
            exp_q.push_back(r);
        end
    endtask

    // Drive one cycle on the falling edge, then advance the model to the next rising edge.
    task automatic step_cycle(input row_t row);
        logic              accept;
        logic [REC_AW-1:0] dk;
        @(negedge clk);
        dk     = m_dec.id[REC_AW-1:0];
        accept = row.fetch_valid && !row.stall && !row.hlt && !m_halted;
        fetch_valid    = row.fetch_valid;
        stall          = row.stall;
        hlt            = row.hlt;
        evt.opcode     = row.stall ? 8'h00 : op_of[dk];   // Only the last decode cycle counts.
        evt.fetch_evt  = evt_code(m_next_id, 0);
        evt.decode_evt = row.stall ? 8'hee : evt_code(m_dec.id, 1);
        evt.exec_evt   = evt_code(m_exe.id, 2);
        evt.mem_evt    = evt_code(m_mem.id, 3);
        evt.wb_evt     = evt_code(m_wb.id, 4);
        if (m_dec.valid && row.stall && scnt_of[dk] != STALL_MAX) begin
            scnt_of[dk] = scnt_of[dk] + 1'b1;
        end
        if (m_dec.valid && row.hlt) begin
            halt_of[dk] = 1'b1;
        end
        m_halted = m_halted || row.hlt;
        if (m_wb.valid) begin
            retire_model(m_wb.id);
        end
        m_wb        = m_mem;
        m_mem       = m_exe;
        m_exe.valid = m_dec.valid && !row.stall;        // Bubble while stalled.
        m_exe.id    = m_dec.id;
        if (!row.stall) begin
            m_dec.valid = accept;
            m_dec.id    = m_next_id;
        end
        if (accept) begin
            op_of[m_next_id[REC_AW-1:0]]   = row.opcode;
            scnt_of[m_next_id[REC_AW-1:0]] = '0;
            halt_of[m_next_id[REC_AW-1:0]] = 1'b0;
            m_next_id                      = m_next_id + 1'b1;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Wishbone master.
    ////////////////////////////////////////////////////////////////////////////
    task automatic bus_access(input wb_addr_t a, input logic w, output wb_data_t d);
        int waits;
        @(negedge clk);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = w;
        adr   = a;
        waits = 0;
        do begin
            @(negedge clk);
            waits++;
        end while (!ack && waits < 8);
        if (!ack) begin
            $display("No Wishbone ack for address %0d at %0t", a, $time);
            $display("Regression failed");
            $fatal(1, "Bus timeout");
        end else begin
            d   = dat_r;
            cyc = 1'b0;                    // Drop the strobe after ack.
            stb = 1'b0;
            we  = 1'b0;
        end
    endtask

    task automatic read_status(output wb_data_t d);
        bus_access(ADDR_STAT, 1'b0, d);
        check_equal(32'(d[FIFO_AW:0]), exp_q.size(), "status count");
        check_equal(32'(d[STAT_EMPTY_BIT]), exp_q.size() == 0, "status empty");
        check_equal(32'(d[STAT_OVF_BIT]), 32'(m_ovf), "status overflow");
        m_ovf = 1'b0;                      // Cleared by this read.
    endtask

    task automatic drain_fifo();
        wb_data_t   d;
        trace_rec_t e;
        bus_access(ADDR_WB, 1'b1, d);      // A write neither pops nor changes count.
        bus_access(ADDR_STAT, 1'b1, d);    // Overflow survives a write.
        read_status(d);
        while (!d[STAT_EMPTY_BIT]) begin
            e = exp_q.pop_front();
            bus_access(ADDR_INFO, 1'b0, d);
            check_equal(d, {3'b000, e.halt, e.stall_cnt, e.opcode, e.id}, "info word");
            bus_access(ADDR_EVTS, 1'b0, d);
            check_equal(d, {e.mem_evt, e.exec_evt, e.decode_evt, e.fetch_evt}, "event word");
            bus_access(ADDR_WB, 1'b0, d);  // Pops the entry.
            check_equal(d, {24'h0, e.wb_evt}, "wb event word");
            read_status(d);
        end
    endtask

    // Empty reads return zero and do not pop.
    task automatic empty_bus_checks();
        wb_data_t d;
        bus_access(ADDR_WB, 1'b0, d);
        check_equal(d, '0, "wb read on empty FIFO");
        read_status(d);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table.
    ////////////////////////////////////////////////////////////////////////////
    task automatic build_table();
        int stall_len [6] = '{1, 2, 7, 15, 16, 20};
        int b;
        int i;
        for (b = 0; b < 4; b++) begin      // Random fetch gaps, at most eight records.
            for (i = 0; i < 8; i++) begin
                add_row(1'($urandom_range(0, 1)), 1'b0, 1'b0, i == 7);
            end
        end
        foreach (stall_len[s]) begin
            add_row(1'b1, 1'b0, 1'b0, 1'b0);          // Stalls in decode.
            repeat (stall_len[s]) add_row(1'($urandom_range(0, 1)), 1'b1, 1'b0, 1'b0);
            add_row(1'b1, 1'b0, 1'b0, 1'b0);
            add_row(1'b1, 1'b0, 1'b0, 1'b1);
        end
        for (i = 0; i < 12; i++) begin     // Overrun the queue.
            add_row(1'b1, 1'b0, 1'b0, i == 11);
        end
        for (i = 0; i < 3; i++) begin      // First one carries the marker.
            add_row(1'b1, 1'b0, 1'b0, i == 2);
        end
        add_row(1'b1, 1'b0, 1'b0, 1'b0);
        add_row(1'b1, 1'b0, 1'b0, 1'b0);
        add_row(1'b1, 1'b0, 1'b1, 1'b0);              // Halt on the second one.
        for (i = 0; i < 5; i++) begin      // Fetches after the halt are ignored.
            add_row(1'b1, 1'b0, 1'b0, i == 4);
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        fetch_valid = 1'b0;
        stall       = 1'b0;
        hlt         = 1'b0;
        evt         = '0;
        cyc         = 1'b0;
        stb         = 1'b0;
        we          = 1'b0;
        adr         = '0;
        err_cnt     = 0;
        m_dec       = '0;
        m_exe       = '0;
        m_mem       = '0;
        m_wb        = '0;
        m_next_id   = '0;
        m_halted    = 1'b0;
        m_ovf       = 1'b0;
        m_lost      = 1'b0;
        foreach (op_of[k]) begin
            op_of[k]   = '0;
            scnt_of[k] = '0;
            halt_of[k] = 1'b0;
        end
        void'($urandom(32'h72ab6b31));
        build_table();
        rows_ready = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        foreach (rows[r]) begin
            step_cycle(rows[r]);
            if (rows[r].drain) begin
                while (m_dec.valid || m_exe.valid || m_mem.valid || m_wb.valid) begin
                    step_cycle('0);
                end
                repeat (3) step_cycle('0);        // Store read, packer, push.
                drain_fifo();
            end
        end
        empty_bus_checks();
        if (err_cnt == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Regression failed");
            $fatal(1, "Checks failed");
        end
    end

    // Watchdog. Twenty cycles per table row.
    initial begin
        wait (rows_ready);
        repeat (rows.size() * 20) @(posedge clk);
        $display("Watchdog expired before the test sequence finished");
        $display("Regression failed");
        $fatal(1, "Timeout");
    end

endmodule

/* files.f */
verilog/trace_pkg.sv
verilog/trace_id_tracker.sv
verilog/trace_record_store.sv
verilog/trace_retire_packer.sv
verilog/trace_fifo_wb.sv
verilog/pipeline_trace_top.sv
verification/pipeline_trace_checker.sv
verification/pipeline_trace_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then decide the result from the simulation log.
verilator --binary --timing --assert -Wno-fatal --top-module pipeline_trace_tb \
    -f files.f -o pipeline_trace_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/pipeline_trace_sim > sim.log 2>&1 ; cat sim.log
grep -q "Regression failed" sim.log && exit 1
grep -q "Regression passed" sim.log || exit 1
